//--- include/group_settings.svh
`ifndef GROUP_SETTINGS_SVH
`define GROUP_SETTINGS_SVH

// Stream word and lane chunk widths in bits
`define GROUP_WORD_BITS 512
`define GROUP_CHUNK_BITS 64

`define GROUP_LEN_BITS 16 // Length field at byte 0 of a value's first word

`define GROUP_LANES 4
`define GROUP_FIFO_DEPTH 16 // Must be a power of two

`define GROUP_CHUNKS_PER_WORD 8

`endif

//--- hw/value_pkg.sv
`include "group_settings.svh"

package value_pkg;

    typedef logic [`GROUP_WORD_BITS-1:0] word_t;

    typedef logic [`GROUP_CHUNK_BITS-1:0] chunk_t;

    // Byte count of a value, header bytes included
    typedef logic [`GROUP_LEN_BITS-1:0] len_t;

    typedef logic [$clog2(`GROUP_CHUNKS_PER_WORD)-1:0] chunk_idx_t;

    typedef enum logic {
        WAIT_WORD, // Ready for the next input word
        SEND_CHUNK // Offering chunks of the held word to the current lane
    } dispatch_state_e;

endpackage

//--- hw/lane_pkg.sv
`include "group_settings.svh"

package lane_pkg;

    typedef logic [$clog2(`GROUP_LANES)-1:0] lane_idx_t;

    // One FIFO entry, last marks the final chunk of a value
    typedef struct packed {
        logic last;
        value_pkg::chunk_t chunk;
    } lane_entry_t;

    typedef enum logic {
        GATHER, // Filling the output word from the current lane
        EMIT // Holding a complete word until the sink takes it
    } collect_state_e;

endpackage

//--- hw/lane_if.sv
interface lane_if;
    import lane_pkg::*;

    lane_entry_t entry;
    logic valid;
    logic ready;
    logic level_full; // FIFO status, high while no entry can be stored

    // Sender and receiver views of the dispatcher to FIFO link
    modport push (output entry, output valid, input ready, input level_full);
    modport push_target (input entry, input valid, output ready, output level_full);

    // Sender and receiver views of the FIFO to collector link
    modport pop (output entry, output valid, input ready, output level_full);
    modport pop_target (input entry, input valid, output ready);

endinterface

//--- hw/lane_fifo.sv
module lane_fifo #(
    parameter int depth = 16
) (
    input logic clk,
    input logic rst,
    lane_if.push_target push,
    lane_if.pop pop
);
    import lane_pkg::*;

    localparam int ptr_bits = $clog2(depth);
    localparam logic [ptr_bits:0] full_count = (ptr_bits + 1)'(depth);

    lane_entry_t mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0] count;
    logic full;
    logic push_xfer;
    logic pop_xfer;

    assign full = (count == full_count);
    assign push_xfer = push.valid && push.ready;
    assign pop_xfer = pop.valid && pop.ready;

    assign push.ready = !full;
    assign push.level_full = full;
    assign pop.level_full = full;

    assign pop.valid = (count != '0);
    assign pop.entry = mem[rd_ptr]; // Written entry shows up here one cycle later

    always_ff @(posedge clk) begin
        if (push_xfer) begin
            mem[wr_ptr] <= push.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_xfer) begin
                wr_ptr <= wr_ptr + 1'b1; // Power-of-two depth wraps for free
            end
            if (pop_xfer) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_xfer && !pop_xfer) begin
                count <= count + 1'b1;
            end else if (pop_xfer && !push_xfer) begin
                count <= count - 1'b1;
            end
        end
    end

    // Equal pointers mean the buffer is either empty or full
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push_xfer |-> (wr_ptr != rd_ptr) || (count == '0));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop_xfer |-> (wr_ptr != rd_ptr) || full);

endmodule

//--- hw/chunk_dispatcher.sv
`include "group_settings.svh"

module chunk_dispatcher (
    input logic clk,
    input logic rst,
    input value_pkg::word_t in_data,
    input logic in_valid,
    output logic in_ready,
    lane_if.push lanes [`GROUP_LANES]
);
    import value_pkg::*;
    import lane_pkg::*;

    localparam len_t chunk_bytes = len_t'(`GROUP_CHUNK_BITS / 8);
    localparam chunk_idx_t last_idx = chunk_idx_t'(`GROUP_CHUNKS_PER_WORD - 1);
    localparam lane_idx_t last_lane = lane_idx_t'(`GROUP_LANES - 1);

    dispatch_state_e state;
    word_t word_q;
    chunk_idx_t idx;
    len_t remaining;
    logic first_word;
    lane_idx_t cur_lane;
    lane_entry_t entry_q;
    logic offer;
    logic accept;
    logic xfer;
    len_t start_len;
    len_t next_len;
    chunk_idx_t next_idx;
    logic [`GROUP_LANES-1:0] lane_valid;
    logic [`GROUP_LANES-1:0] lane_ready;
    logic [`GROUP_LANES-1:0] lane_full;

    for (genvar l = 0; l < `GROUP_LANES; l++) begin : g_lane
        assign lanes[l].entry = entry_q;
        assign lanes[l].valid = lane_valid[l];
        assign lane_ready[l] = lanes[l].ready;
        assign lane_full[l] = lanes[l].level_full;

        // A full lane must leave the pending chunk untouched
        a_hold_on_full: assert property (@(posedge clk) disable iff (rst)
            lane_valid[l] && lane_full[l] |=> lane_valid[l] && $stable(entry_q));
    end

    always_comb begin
        lane_valid = '0;
        lane_valid[cur_lane] = offer;
    end

    assign accept = in_valid && in_ready;
    assign xfer = offer && lane_ready[cur_lane];
    assign start_len = first_word ? in_data[`GROUP_LEN_BITS-1:0] : remaining;
    assign next_len = remaining - chunk_bytes;
    assign next_idx = idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_WORD;
            in_ready <= 1'b0;
            offer <= 1'b0;
            first_word <= 1'b1;
            cur_lane <= '0;
        end else begin
            case (state)
                WAIT_WORD: begin
                    in_ready <= 1'b1;
                    if (accept) begin
                        in_ready <= 1'b0;
                        offer <= 1'b1; // First chunk goes out next cycle
                        first_word <= 1'b0;
                        state <= SEND_CHUNK;
                    end
                end
                SEND_CHUNK: begin
                    if (xfer && (entry_q.last || idx == last_idx)) begin
                        offer <= 1'b0;
                        in_ready <= 1'b1;
                        state <= WAIT_WORD;
                    end
                    if (xfer && entry_q.last) begin
                        first_word <= 1'b1;
                        cur_lane <= (cur_lane == last_lane) ? '0 : cur_lane + 1'b1;
                    end
                end
                default: state <= WAIT_WORD;
            endcase
        end
    end

    // remaining counts the bytes from the offered chunk to the end of the value
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= in_data;
            idx <= '0;
            remaining <= start_len;
            entry_q.chunk <= in_data[0 +: `GROUP_CHUNK_BITS];
            entry_q.last <= (start_len <= chunk_bytes);
        end else if (xfer && !entry_q.last) begin
            remaining <= next_len;
            if (idx != last_idx) begin
                idx <= next_idx;
                entry_q.chunk <= word_q[next_idx * `GROUP_CHUNK_BITS +: `GROUP_CHUNK_BITS];
                entry_q.last <= (next_len <= chunk_bytes);
            end
        end
    end

    a_lane_fixed: assert property (@(posedge clk) disable iff (rst)
        offer && !xfer |=> offer && $stable(cur_lane));

endmodule

//--- hw/chunk_collector.sv
`include "group_settings.svh"

module chunk_collector (
    input logic clk,
    input logic rst,
    lane_if.pop_target lanes [`GROUP_LANES],
    output value_pkg::word_t out_data,
    output logic out_valid,
    output logic out_last,
    input logic out_ready
);
    import value_pkg::*;
    import lane_pkg::*;

    localparam chunk_idx_t last_pos = chunk_idx_t'(`GROUP_CHUNKS_PER_WORD - 1);
    localparam lane_idx_t last_lane = lane_idx_t'(`GROUP_LANES - 1);

    collect_state_e state;
    lane_idx_t cur_lane;
    chunk_idx_t pos;
    lane_entry_t lane_entry [`GROUP_LANES];
    logic [`GROUP_LANES-1:0] lane_valid;
    lane_entry_t cur_entry;
    logic take;

    for (genvar l = 0; l < `GROUP_LANES; l++) begin : g_lane
        assign lane_entry[l] = lanes[l].entry;
        assign lane_valid[l] = lanes[l].valid;
        assign lanes[l].ready = (state == GATHER) && (cur_lane == lane_idx_t'(l));
    end

    assign cur_entry = lane_entry[cur_lane];
    assign take = (state == GATHER) && lane_valid[cur_lane];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GATHER;
            cur_lane <= '0;
            pos <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            case (state)
                GATHER: begin
                    if (take && (cur_entry.last || pos == last_pos)) begin
                        out_valid <= 1'b1;
                        out_last <= cur_entry.last;
                        pos <= '0;
                        state <= EMIT;
                    end else if (take) begin
                        pos <= pos + 1'b1;
                    end
                end
                EMIT: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        out_last <= 1'b0;
                        state <= GATHER;
                        if (out_last) begin
                            cur_lane <= (cur_lane == last_lane) ? '0 : cur_lane + 1'b1;
                        end
                    end
                end
                default: state <= GATHER;
            endcase
        end
    end

    // A value that ends mid-word gets zero chunks above its last one
    always_ff @(posedge clk) begin
        if (take) begin
            for (int k = 0; k < `GROUP_CHUNKS_PER_WORD; k++) begin
                if (k == int'(pos)) begin
                    out_data[k*`GROUP_CHUNK_BITS +: `GROUP_CHUNK_BITS] <= cur_entry.chunk;
                end else if (k > int'(pos) && cur_entry.last) begin
                    out_data[k*`GROUP_CHUNK_BITS +: `GROUP_CHUNK_BITS] <= '0;
                end
            end
        end
    end

    a_hold_output: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

//--- hw/decompress_group.sv
`include "group_settings.svh"

module decompress_group (
    input logic clk,
    input logic rst,
    input value_pkg::word_t in_data,
    input logic in_valid,
    output logic in_ready,
    output value_pkg::word_t out_data,
    output logic out_valid,
    output logic out_last,
    input logic out_ready
);

    lane_if push_link [`GROUP_LANES] (); // Dispatcher to lane FIFOs
    lane_if pop_link [`GROUP_LANES] (); // Lane FIFOs to collector

    chunk_dispatcher u_dispatcher (
        .clk(clk),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .lanes(push_link)
    );

    for (genvar l = 0; l < `GROUP_LANES; l++) begin : g_lane
        lane_fifo #(
            .depth(`GROUP_FIFO_DEPTH)
        ) u_fifo (
            .clk(clk),
            .rst(rst),
            .push(push_link[l]),
            .pop(pop_link[l])
        );
    end

    chunk_collector u_collector (
        .clk(clk),
        .rst(rst),
        .lanes(pop_link),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .out_ready(out_ready)
    );

endmodule

//--- sim/tb_decompress_group.sv
`include "group_settings.svh"

module tb_decompress_group;
    timeunit 1ns;
    timeprecision 1ps;

    import value_pkg::*;

    localparam int wait_limit = 2000; // Cycles that any single wait may take

    logic clk;
    logic rst;
    word_t in_data;
    logic in_valid;
    logic in_ready;
    word_t out_data;
    logic out_valid;
    logic out_last;
    logic out_ready;

    logic [15:0] lfsr;
    int checks;
    int errors;
    int value_lens[$];
    word_t in_words[$];
    word_t exp_words[$];
    logic exp_last[$];

    decompress_group dut (
        .clk(clk),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Galois form with taps 16 14 13 11
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    function automatic word_t random_word();
        word_t w;
        for (int b = 0; b < `GROUP_WORD_BITS; b++) begin
            w[b] = take_bit();
        end
        return w;
    endfunction

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timeout at %0t: %s", $time, what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    endtask

    // Input words of one value and the output words it should turn into
    task automatic build_value(input int len);
        int chunks;
        int words;
        int used;
        word_t w;
        chunks = (len + 7) / 8;
        if (chunks == 0) begin
            chunks = 1; // A value always has at least one chunk
        end
        words = (chunks + `GROUP_CHUNKS_PER_WORD - 1) / `GROUP_CHUNKS_PER_WORD;
        used = chunks - `GROUP_CHUNKS_PER_WORD * (words - 1);
        for (int i = 0; i < words; i++) begin
            w = random_word();
            if (i == 0) begin
                w[`GROUP_LEN_BITS-1:0] = len[`GROUP_LEN_BITS-1:0];
            end
            in_words.push_back(w);
            if (i == words - 1) begin
                for (int k = used; k < `GROUP_CHUNKS_PER_WORD; k++) begin
                    w[k*`GROUP_CHUNK_BITS +: `GROUP_CHUNK_BITS] = '0;
                end
            end
            exp_words.push_back(w);
            exp_last.push_back(i == words - 1);
        end
    endtask

    task automatic drive_words();
        int waited;
        while (in_words.size() > 0) begin
            in_data = in_words.pop_front();
            in_valid = 1'b1;
            waited = 0;
            while (!in_ready) begin
                @(negedge clk);
                waited++;
                if (waited > wait_limit) begin
                    stop_on_timeout("in_ready stayed low while a word was offered");
                end
            end
            @(negedge clk); // The word was taken on the edge just passed
        end
        in_valid = 1'b0;
        in_data = '0;
    endtask

    task automatic collect_words(input int count, input logic random_ready);
        int got;
        int waited;
        logic b0;
        logic b1;
        logic rdy;
        logic held;
        word_t held_data;
        word_t exp_data;
        logic exp_l;
        got = 0;
        waited = 0;
        held = 1'b0;
        held_data = '0;
        while (got < count) begin
            @(negedge clk);
            if (held) begin
                checks++;
                assert (out_valid) else begin
                    errors++;
                    $display("** Error at %0t: out_valid got %b expected 1", $time, out_valid);
                end
                assert (out_data == held_data) else begin
                    errors++;
                    $display("** Error at %0t: out_data got %h expected %h",
                        $time, out_data, held_data);
                end
            end
            b0 = take_bit();
            b1 = take_bit();
            rdy = random_ready ? (b0 & b1) : 1'b1;
            out_ready = rdy;
            if (out_valid && rdy) begin
                exp_data = exp_words.pop_front();
                exp_l = exp_last.pop_front();
                checks++;
                assert (out_data == exp_data) else begin
                    errors++;
                    $display("** Error at %0t: out_data of word %0d got %h expected %h",
                        $time, got, out_data, exp_data);
                end
                assert (out_last == exp_l) else begin
                    errors++;
                    $display("** Error at %0t: out_last of word %0d got %b expected %b",
                        $time, got, out_last, exp_l);
                end
                got++;
                waited = 0;
                held = 1'b0;
            end else begin
                held = out_valid; // Stalled word must stay put until taken
                held_data = out_data;
                waited++;
                if (waited > wait_limit) begin
                    stop_on_timeout("no output word arrived");
                end
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic check_idle();
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (!out_valid) else begin
                errors++;
                $display("** Error at %0t: out_valid got %b expected 0", $time, out_valid);
            end
        end
    endtask

    task automatic run_values(input logic random_ready);
        int total;
        foreach (value_lens[i]) begin
            build_value(value_lens[i]);
        end
        total = exp_words.size();
        fork
            drive_words();
            collect_words(total, random_ready);
        join
        value_lens.delete();
        check_idle();
    endtask

    task automatic reset_state_test();
        int waited;
        rst = 1'b1;
        repeat (8) begin
            @(negedge clk);
            checks++;
            assert (!out_valid) else begin
                errors++;
                $display("** Error at %0t: out_valid got %b expected 0", $time, out_valid);
            end
            assert (!in_ready) else begin
                errors++;
                $display("** Error at %0t: in_ready got %b expected 0", $time, in_ready);
            end
        end
        rst = 1'b0;
        waited = 0;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            checks++;
            assert (!out_valid) else begin
                errors++;
                $display("** Error at %0t: out_valid got %b expected 0", $time, out_valid);
            end
            if (waited > wait_limit) begin
                stop_on_timeout("in_ready did not rise after reset");
            end
        end
    endtask

    task automatic short_value_test();
        value_lens.push_back(5);
        run_values(1'b0);
    endtask

    task automatic multi_word_test();
        value_lens.push_back(150); // 19 chunks over three words
        run_values(1'b0);
    endtask

    task automatic lane_rotation_test();
        for (int i = 0; i < `GROUP_LANES + 2; i++) begin
            value_lens.push_back(23 + 61 * i);
        end
        run_values(1'b0);
    endtask

    task automatic back_pressure_test();
        for (int i = 0; i < 4 * `GROUP_LANES; i++) begin
            value_lens.push_back((i * 97 + 5) % 520); // Far more chunks than the FIFOs hold
        end
        run_values(1'b1);
    endtask

    initial begin
        rst = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        lfsr = 16'd19;
        checks = 0;
        errors = 0;
        reset_state_test();
        short_value_test();
        multi_word_test();
        lane_rotation_test();
        back_pressure_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- decompress_group.f
+incdir+include
hw/value_pkg.sv
hw/lane_pkg.sv
hw/lane_if.sv
hw/lane_fifo.sv
hw/chunk_dispatcher.sv
hw/chunk_collector.sv
hw/decompress_group.sv
sim/tb_decompress_group.sv

//--- Makefile
TOOL       := verilator
TOP        := tb_decompress_group
FILELIST   := decompress_group.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
PASS_TEXT  := Simulation passed

.PHONY: run build lint clean

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
